// File: compile.f
logic/axi_wr_pkg.sv
logic/wr_ctrl_fsm.sv
logic/wr_req_counter.sv
logic/ost_table.sv
logic/w_burst_engine.sv
logic/axi_wr_master.sv
verif/axi_slave_model.sv
verif/tb_axi_wr_master.sv

// File: logic/axi_wr_master.sv
/* AXI write master top. Runs REQ_TOTAL bursts per start handshake with up to
   OST_DEPTH in flight. b_ready is always high. */
`timescale 1ns/10ps
`default_nettype none

module axi_wr_master (
    input  wire                  clk,
    input  wire                  rst_n,
    input  logic                 start_req,
    output logic                 start_ack,
    // AW channel
    output logic                 aw_valid,
    input  logic                 aw_ready,
    output axi_wr_pkg::aw_chan_t aw,
    // W channel
    output logic                 w_valid,
    input  logic                 w_ready,
    output axi_wr_pkg::w_chan_t  w,
    // B channel
    input  logic                 b_valid,
    output logic                 b_ready,
    input  axi_wr_pkg::b_chan_t  b,
    output logic                 resp_err
);
    import axi_wr_pkg::*;

    logic                 alloc_en;
    logic                 run_start;
    logic                 full;
    logic                 all_alloc;
    logic                 all_retired;
    logic                 retire;
    logic                 b_err;
    logic [REQ_CNT_W-1:0] req_num;
    logic                 w_slot_valid;
    aw_chan_t             w_head;
    logic                 w_burst_done;

    assign b_ready = 1'b1;

    wr_ctrl_fsm u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_req   (start_req),
        .full        (full),
        .all_alloc   (all_alloc),
        .all_retired (all_retired),
        .b_err       (b_err),
        .start_ack   (start_ack),
        .alloc_en    (alloc_en),
        .run_start   (run_start),
        .resp_err    (resp_err)
    );

    wr_req_counter u_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .run_start   (run_start),
        .alloc_en    (alloc_en),
        .retire      (retire),
        .req_num     (req_num),
        .all_alloc   (all_alloc),
        .all_retired (all_retired)
    );

    ost_table u_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_en     (alloc_en),
        .req_num      (req_num),
        .aw_ready     (aw_ready),
        .w_burst_done (w_burst_done),
        .b_valid      (b_valid),
        .b            (b),
        .full         (full),
        .aw_valid     (aw_valid),
        .aw           (aw),
        .w_slot_valid (w_slot_valid),
        .w_head       (w_head),
        .retire       (retire),
        .b_err        (b_err)
    );

    w_burst_engine u_w (
        .clk          (clk),
        .rst_n        (rst_n),
        .w_slot_valid (w_slot_valid),
        .w_head       (w_head),
        .w_ready      (w_ready),
        .w_valid      (w_valid),
        .w            (w),
        .w_burst_done (w_burst_done)
    );

endmodule

`default_nettype wire

// File: logic/axi_wr_pkg.sv
/* Shared widths, types and the burst profile table for the AXI write master.
   Every profile is 4 beats of 4 bytes; WRAP totals must be a power of two. */
`default_nettype none

package axi_wr_pkg;

    // ---------------------------------------------------------------------
    // Widths and depths
    // ---------------------------------------------------------------------
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 64;
    localparam int STRB_W      = 8;
    localparam int ID_W        = 4;
    localparam int LEN_W       = 8;
    localparam int OST_DEPTH   = 4;   // Outstanding slots
    localparam int SLOT_W      = 2;
    localparam int REQ_TOTAL   = 16;  // Bursts per run
    localparam int REQ_CNT_W   = 5;
    localparam int PROFILE_NUM = 8;

    localparam logic [2:0] BEAT_SIZE = 3'd2;   // 4-byte beats
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2,
        ACK   = 2'd3
    } fsm_state_e;

    // ---------------------------------------------------------------------
    // AXI channel payloads
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;    // Beats minus one
        logic [2:0]        size;
        burst_e            burst;
    } aw_chan_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_chan_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } b_chan_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        burst_e            burst;
        logic [LEN_W-1:0]  len;
    } burst_profile_t;

    localparam burst_profile_t PROFILE_TABLE [PROFILE_NUM] = '{
        '{32'h0000_0000, INCR,  8'd3},
        '{32'h0000_0010, INCR,  8'd3},
        '{32'h0000_0020, INCR,  8'd3},
        '{32'h0000_0030, FIXED, 8'd3},
        '{32'h0000_0034, WRAP,  8'd3},   // Wraps inside 0x30..0x3f
        '{32'h0000_0038, WRAP,  8'd3},
        '{32'h0000_0040, FIXED, 8'd3},
        '{32'h0000_0080, INCR,  8'd3}
    };

    // Profile picked by the low three bits of the request number
    function automatic burst_profile_t profile_of(input logic [REQ_CNT_W-1:0] req_num);
        return PROFILE_TABLE[req_num[2:0]];
    endfunction

endpackage

`default_nettype wire

// File: logic/ost_table.sv
/* Outstanding slot table. IDs must be unique among live slots, which holds
   while OST_DEPTH is below 2**ID_W. B responses may return in any order. */
`timescale 1ns/10ps
`default_nettype none

module ost_table (
    input  wire                              clk,
    input  wire                              rst_n,
    input  logic                             alloc_en,
    input  logic [axi_wr_pkg::REQ_CNT_W-1:0] req_num,
    input  logic                             aw_ready,
    input  logic                             w_burst_done,
    input  logic                             b_valid,
    input  axi_wr_pkg::b_chan_t              b,
    output logic                             full,
    output logic                             aw_valid,
    output axi_wr_pkg::aw_chan_t             aw,
    output logic                             w_slot_valid,
    output axi_wr_pkg::aw_chan_t             w_head,
    output logic                             retire,
    output logic                             b_err
);
    import axi_wr_pkg::*;

    logic [OST_DEPTH-1:0] slot_vld;   // Slot in use, alloc to B
    logic [OST_DEPTH-1:0] b_pend;     // AW sent, waiting for B
    logic [OST_DEPTH-1:0] alloc_oh;
    logic [OST_DEPTH-1:0] aw_oh;
    logic [OST_DEPTH-1:0] b_hit;
    aw_chan_t             slot_rec [OST_DEPTH];

    logic [SLOT_W-1:0]    free_idx;
    burst_profile_t       prof;
    logic                 aw_hs;
    logic [SLOT_W-1:0]    aw_slot;
    logic [SLOT_W-1:0]    w_slot;

    // Queue 0 is AW issue order, queue 1 is W order
    logic [1:0]             q_push;
    logic [1:0]             q_pop;
    logic [1:0]             q_empty;
    logic [1:0][SLOT_W-1:0] q_din;
    logic [1:0][SLOT_W-1:0] q_head;

    // ---------------------------------------------------------------------
    // Allocation
    // ---------------------------------------------------------------------
    always_comb begin
        free_idx = '0;
        for (int i = OST_DEPTH - 1; i >= 0; i--) begin
            if (!slot_vld[i]) free_idx = SLOT_W'(i);   // Lowest free wins
        end
    end

    assign full     = &slot_vld;
    assign prof     = profile_of(req_num);
    assign alloc_oh = alloc_en ? (OST_DEPTH'(1) << free_idx) : '0;

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            slot_rec[free_idx] <= aw_chan_t'{
                id:    req_num[ID_W-1:0],
                addr:  prof.addr,
                len:   prof.len,
                size:  BEAT_SIZE,
                burst: prof.burst
            };
        end
    end

    // ---------------------------------------------------------------------
    // Order queues
    // ---------------------------------------------------------------------
    assign q_push = {aw_hs, alloc_en};
    assign q_pop  = {w_burst_done, aw_hs};
    assign q_din  = {aw_slot, free_idx};

    for (genvar q = 0; q < 2; q++) begin : g_queue
        logic [SLOT_W-1:0] mem [OST_DEPTH];
        logic [SLOT_W:0]   wr_ptr;
        logic [SLOT_W:0]   rd_ptr;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (q_push[q]) wr_ptr <= wr_ptr + 1'b1;
                if (q_pop[q])  rd_ptr <= rd_ptr + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (q_push[q]) mem[wr_ptr[SLOT_W-1:0]] <= q_din[q];
        end

        assign q_empty[q] = (wr_ptr == rd_ptr);
        assign q_head[q]  = mem[rd_ptr[SLOT_W-1:0]];
    end

    // ---------------------------------------------------------------------
    // AW issue, W head, B retirement
    // ---------------------------------------------------------------------
    assign aw_slot  = q_head[0];
    assign aw_valid = !q_empty[0];
    assign aw       = slot_rec[aw_slot];
    assign aw_hs    = aw_valid && aw_ready;
    assign aw_oh    = aw_hs ? (OST_DEPTH'(1) << aw_slot) : '0;

    assign w_slot       = q_head[1];
    assign w_slot_valid = !q_empty[1];
    assign w_head       = slot_rec[w_slot];

    always_comb begin
        for (int i = 0; i < OST_DEPTH; i++) begin
            b_hit[i] = b_valid && b_pend[i] && (slot_rec[i].id == b.id);
        end
    end

    assign retire = b_valid;   // b_ready is tied high
    assign b_err  = b_valid && (b.resp != RESP_OKAY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld <= '0;
            b_pend   <= '0;
        end else begin
            slot_vld <= (slot_vld | alloc_oh) & ~b_hit;
            b_pend   <= (b_pend | aw_oh) & ~b_hit;
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw));

    a_b_known_id: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid |-> |b_hit);

endmodule

`default_nettype wire

// File: logic/w_burst_engine.sv
/* Generates W beats on the fly for the head of the W order queue.
   One idle cycle between bursts; WRAP needs a power-of-two total size. */
`timescale 1ns/10ps
`default_nettype none

module w_burst_engine (
    input  wire                  clk,
    input  wire                  rst_n,
    input  logic                 w_slot_valid,
    input  axi_wr_pkg::aw_chan_t w_head,
    input  logic                 w_ready,
    output logic                 w_valid,
    output axi_wr_pkg::w_chan_t  w,
    output logic                 w_burst_done
);
    import axi_wr_pkg::*;

    logic [LEN_W-1:0]  beat_idx;
    logic [ADDR_W-1:0] cur_addr;
    logic              w_hs;
    logic              beat_last;

    // ---------------------------------------------------------------------
    // Address of beat k within the burst described by hdr
    // ---------------------------------------------------------------------
    function automatic logic [ADDR_W-1:0] beat_addr(input aw_chan_t hdr,
                                                    input logic [LEN_W-1:0] k);
        logic [ADDR_W-1:0] nbytes;
        logic [ADDR_W-1:0] total;
        logic [ADDR_W-1:0] aligned;
        logic [ADDR_W-1:0] boundary;
        logic [ADDR_W-1:0] step;

        nbytes   = ADDR_W'(1) << hdr.size;
        total    = nbytes * (ADDR_W'(hdr.len) + 1'b1);   // Bytes in whole burst
        aligned  = hdr.addr & ~(nbytes - 1'b1);
        boundary = hdr.addr & ~(total - 1'b1);
        step     = ADDR_W'(k) * nbytes;
        case (hdr.burst)
            FIXED:   beat_addr = hdr.addr;
            WRAP:    beat_addr = boundary + ((hdr.addr - boundary + step) & (total - 1'b1));
            default: beat_addr = aligned + step;   // INCR
        endcase
    endfunction

    assign w_hs         = w_valid && w_ready;
    assign beat_last    = (beat_idx == w_head.len);
    assign w_burst_done = w_hs && beat_last;

    // ---------------------------------------------------------------------
    // Beat sequencing
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_valid  <= 1'b0;
            beat_idx <= '0;
        end else if (!w_valid) begin
            if (w_slot_valid) begin   // Next burst ready at queue head
                w_valid  <= 1'b1;
                beat_idx <= '0;
            end
        end else if (w_hs) begin
            if (beat_last) begin
                w_valid <= 1'b0;      // Queue pops on this edge
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!w_valid && w_slot_valid) begin
            cur_addr <= beat_addr(w_head, '0);
        end else if (w_hs && !beat_last) begin
            cur_addr <= beat_addr(w_head, beat_idx + 1'b1);
        end
    end

    // Data carries the ID just above the beat address
    always_comb begin
        w.data = {{(DATA_W - ID_W - ADDR_W){1'b0}}, w_head.id, cur_addr};
        w.strb = {STRB_W{1'b1}};
        w.last = beat_last;
    end

    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w));

endmodule

`default_nettype wire

// File: logic/wr_ctrl_fsm.sv
/* Run sequencer. start_req/start_ack follow a four-phase handshake, so a new
   run needs start_req low and then high again. resp_err clears at run start. */
`timescale 1ns/10ps
`default_nettype none

module wr_ctrl_fsm (
    input  wire  clk,
    input  wire  rst_n,
    input  logic start_req,
    input  logic full,
    input  logic all_alloc,
    input  logic all_retired,
    input  logic b_err,
    output logic start_ack,
    output logic alloc_en,
    output logic run_start,
    output logic resp_err
);
    import axi_wr_pkg::*;

    fsm_state_e state;
    fsm_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:  if (start_req) state_nxt = RUN;
            RUN:   if (all_alloc) state_nxt = DRAIN;
            DRAIN: if (all_retired) state_nxt = ACK;
            ACK:   if (!start_req) state_nxt = IDLE;   // Requester released
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign run_start = (state == IDLE) && start_req;
    assign alloc_en  = (state == RUN) && !full && !all_alloc;   // One slot per cycle
    assign start_ack = (state == ACK);

    // Sticky error over one run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_err <= 1'b0;
        end else if (run_start) begin
            resp_err <= 1'b0;
        end else if (b_err) begin
            resp_err <= 1'b1;
        end
    end

    // Ack only answers a request that is still up
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(start_ack) |-> start_req);

endmodule

`default_nettype wire

// File: logic/wr_req_counter.sv
/* Counts allocations and retirements within one run; both clear on run_start.
   req_num doubles as the number of the next request to allocate. */
`timescale 1ns/10ps
`default_nettype none

module wr_req_counter (
    input  wire                              clk,
    input  wire                              rst_n,
    input  logic                             run_start,
    input  logic                             alloc_en,
    input  logic                             retire,
    output logic [axi_wr_pkg::REQ_CNT_W-1:0] req_num,
    output logic                             all_alloc,
    output logic                             all_retired
);
    import axi_wr_pkg::*;

    logic [REQ_CNT_W-1:0] alloc_cnt;
    logic [REQ_CNT_W-1:0] ret_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_cnt <= '0;
            ret_cnt   <= '0;
        end else if (run_start) begin
            alloc_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            if (alloc_en) alloc_cnt <= alloc_cnt + 1'b1;
            if (retire)   ret_cnt   <= ret_cnt + 1'b1;
        end
    end

    assign req_num     = alloc_cnt;
    assign all_alloc   = (alloc_cnt == REQ_TOTAL);
    assign all_retired = (ret_cnt == REQ_TOTAL);

    // A B response can only follow its own allocation
    a_ret_le_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        ret_cnt <= alloc_cnt);

endmodule

`default_nettype wire

// File: verif/axi_slave_model.sv
/* AXI write slave for simulation. Ready stalls and B delays come from a
   16-bit Galois LFSR. B follows the last W beat of each burst, in AW order. */
`timescale 1ns/10ps
`default_nettype none

module axi_slave_model (
    input  wire                  clk,
    input  wire                  rst_n,
    input  logic                 err_en,      // SLVERR for ID 9 when set
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi_wr_pkg::aw_chan_t aw,
    input  logic                 w_valid,
    output logic                 w_ready,
    input  axi_wr_pkg::w_chan_t  w,
    output logic                 b_valid,
    input  logic                 b_ready,
    output axi_wr_pkg::b_chan_t  b,
    output int                   beat_cnt     // Accepted W beats
);
    import axi_wr_pkg::*;

    logic [15:0]     lfsr;
    logic [ID_W-1:0] aw_ids [$];   // AW taken, W burst still open
    logic [ID_W-1:0] b_ids [$];    // Bursts waiting for their B
    int              b_wait;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step for each bit taken
    function automatic logic [3:0] take_bits(input int n);
        logic [3:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    initial begin
        lfsr     = 16'd58933;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b        = '0;
        beat_cnt = 0;
        b_wait   = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            b        <= '0;
            beat_cnt <= 0;
            aw_ids.delete();
            b_ids.delete();
        end else begin
            aw_ready <= (take_bits(2) != 4'd0);   // Stalls about one cycle in four
            w_ready  <= (take_bits(2) != 4'd0);
            if (aw_valid && aw_ready) aw_ids.push_back(aw.id);
            if (w_valid && w_ready) begin
                beat_cnt <= beat_cnt + 1;
                if (w.last) b_ids.push_back(aw_ids.pop_front());
            end
            // B is held while not taken
            if (!b_valid || b_ready) begin
                if (b_wait > 0) begin
                    b_valid <= 1'b0;
                    b_wait  = b_wait - 1;
                end else if (b_ids.size() > 0) begin
                    b_valid <= 1'b1;
                    b.id    <= b_ids[0];
                    b.resp  <= (err_en && b_ids[0] == 4'd9) ? 2'b10 : RESP_OKAY;
                    void'(b_ids.pop_front());
                    b_wait  = take_bits(2);   // Up to 3 idle cycles
                end else begin
                    b_valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_axi_wr_master.sv
/* Testbench for the AXI write master. Two runs of 16 bursts against a
   stalling slave, with SLVERR on ID 9 in the first run only. */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_wr_master;
    import axi_wr_pkg::*;

    localparam int TIMEOUT_CYCLES = 2 * REQ_TOTAL * 4 * 8 + 200;

    logic     clk;
    logic     rst_n;
    logic     start_req;
    logic     start_ack;
    logic     aw_valid;
    logic     aw_ready;
    aw_chan_t aw;
    logic     w_valid;
    logic     w_ready;
    w_chan_t  w;
    logic     b_valid;
    logic     b_ready;
    b_chan_t  b;
    logic     resp_err;
    logic     err_en;
    int       slave_beats;

    int check_cnt   = 0;
    int err_cnt     = 0;
    int cycle_cnt   = 0;
    int aw_total    = 0;
    int beat_total  = 0;
    int b_total     = 0;
    int outstanding = 0;
    int ack_cnt     = 0;
    int beat_k      = 0;
    logic ack_d     = 1'b0;
    int w_reqs [$];   // Request numbers in W order

    axi_wr_master DUT (
        .clk (clk), .rst_n (rst_n), .start_req (start_req), .start_ack (start_ack),
        .aw_valid (aw_valid), .aw_ready (aw_ready), .aw (aw),
        .w_valid (w_valid), .w_ready (w_ready), .w (w),
        .b_valid (b_valid), .b_ready (b_ready), .b (b), .resp_err (resp_err)
    );

    axi_slave_model u_slave (
        .clk (clk), .rst_n (rst_n), .err_en (err_en),
        .aw_valid (aw_valid), .aw_ready (aw_ready), .aw (aw),
        .w_valid (w_valid), .w_ready (w_ready), .w (w),
        .b_valid (b_valid), .b_ready (b_ready), .b (b), .beat_cnt (slave_beats)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // Expected bursts
    // ------------------------------------------------------------------
    function automatic burst_profile_t exp_profile(input int req);
        burst_profile_t p;
        case (req % 8)
            0:       p = '{32'h00, INCR, 8'd3};
            1:       p = '{32'h10, INCR, 8'd3};
            2:       p = '{32'h20, INCR, 8'd3};
            3:       p = '{32'h30, FIXED, 8'd3};
            4:       p = '{32'h34, WRAP, 8'd3};
            5:       p = '{32'h38, WRAP, 8'd3};
            6:       p = '{32'h40, FIXED, 8'd3};
            default: p = '{32'h80, INCR, 8'd3};
        endcase
        return p;
    endfunction

    // Beat data is the ID over the beat address
    function automatic logic [DATA_W-1:0] exp_beat(input int req, input int k);
        burst_profile_t    p;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] lo;
        p  = exp_profile(req);
        lo = p.addr & ~32'hF;   // 16-byte wrap window
        case (p.burst)
            FIXED:   a = p.addr;
            WRAP:    a = lo + ((p.addr - lo + 4 * k) % 16);
            default: a = (p.addr & ~32'h3) + 4 * k;
        endcase
        return {28'd0, 4'(req % 16), a};
    endfunction

    // ------------------------------------------------------------------
    // Handshake monitor
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        int             ost_now;
        int             req;
        burst_profile_t p;
        if (rst_n) begin
            ost_now = outstanding;
            if (w_valid && w_ready) begin
                check_eq(w_reqs.size() > 0, 1, "W beat follows its AW");
                req = w_reqs[0];
                check_eq(w.data, exp_beat(req, beat_k), "W data");
                check_eq(w.strb, 8'hFF, "W strobe");
                check_eq(w.last, beat_k == 3, "W last");
                beat_total <= beat_total + 1;
                if (beat_k == 3) begin
                    void'(w_reqs.pop_front());
                    beat_k = 0;
                end else begin
                    beat_k++;
                end
            end
            if (aw_valid && aw_ready) begin
                req = aw_total % REQ_TOTAL;   // AW in request order
                p   = exp_profile(req);
                check_eq(aw.id, req % 16, "AW id");
                check_eq(aw.addr, p.addr, "AW addr");
                check_eq(aw.burst, p.burst, "AW burst");
                check_eq(aw.len, p.len, "AW len");
                check_eq(aw.size, 3'd2, "AW size");
                w_reqs.push_back(req);
                aw_total <= aw_total + 1;
                ost_now++;
            end
            if (b_valid && b_ready) begin
                b_total <= b_total + 1;
                ost_now--;
            end
            if (aw_valid && aw_ready) check_eq(ost_now <= OST_DEPTH, 1, "outstanding bursts");
            outstanding <= ost_now;
            ack_d       <= start_ack;
            if (start_ack && !ack_d) begin
                ack_cnt <= ack_cnt + 1;
                check_eq(b_total, REQ_TOTAL * (ack_cnt + 1), "B count at start_ack");
                check_eq(start_req, 1'b1, "start_req high at start_ack");
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic do_run(input int run_idx, input logic slverr);
        int aw_before;
        int beats_before;
        aw_before    = aw_total;
        beats_before = beat_total;
        err_en    <= slverr;
        start_req <= 1'b1;
        do @(posedge clk); while (!aw_valid);
        check_eq(resp_err, 1'b0, "resp_err cleared at run start");
        while (!start_ack) @(posedge clk);
        check_eq(aw_total - aw_before, REQ_TOTAL, "AW bursts per run");
        check_eq(beat_total - beats_before, REQ_TOTAL * 4, "W beats per run");
        check_eq(slave_beats, REQ_TOTAL * 4 * run_idx, "beats logged by slave");
        check_eq(resp_err, slverr, "resp_err after run");
        start_req <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        check_eq(start_ack, 1'b0, "start_ack released");   // One cycle after req low
        $display("Run %0d done: %0d bursts, %0d beats, %0d errors so far",
                 run_idx, aw_total - aw_before, beat_total - beats_before, err_cnt);
    endtask

    initial begin
        rst_n     = 1'b0;
        start_req = 1'b0;
        err_en    = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_eq(aw_valid, 1'b0, "aw_valid after reset");
        check_eq(w_valid, 1'b0, "w_valid after reset");
        check_eq(start_ack, 1'b0, "start_ack after reset");
        check_eq(b_ready, 1'b1, "b_ready tied high");
        do_run(1, 1'b1);
        do_run(2, 1'b0);
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
